// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_soc_top
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: hdl/cmd_monitor.sv
`default_nettype none

module cmd_monitor (
   input  wire               clk_i,
   input  wire               arst_n_i,
   // bytes from the receiver
   input  wire               rx_valid_i,
   input  soc_pkg::byte_t    rx_byte_i,
   // transmitter
   input  wire               tx_busy_i,
   output logic              tx_start_o,
   output soc_pkg::byte_t    tx_byte_o,
   // external memory with four-phase req/ack
   output soc_pkg::mem_req_t mem_req_o,
   output logic              mem_req_valid_o,
   input  wire               mem_ack_i,
   input  soc_pkg::byte_t    mem_rdata_i,
   output logic              trap_o
);

   soc_pkg::mon_state_t state;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state           <= soc_pkg::MON_IDLE;
         mem_req_valid_o <= 1'b0;
         tx_start_o      <= 1'b0;
         trap_o          <= 1'b0;
      end else begin
         tx_start_o <= 1'b0;
         unique case (state)
            soc_pkg::MON_IDLE: begin
               if (rx_valid_i) begin
                  if ((rx_byte_i == soc_pkg::CMD_WRITE) ||
                      (rx_byte_i == soc_pkg::CMD_READ)) begin
                     state <= soc_pkg::MON_GET_ADDR;
                  end else begin
                     // sticky until reset
                     trap_o <= 1'b1;
                     state  <= soc_pkg::MON_TRAP;
                  end
               end
            end
            soc_pkg::MON_GET_ADDR: begin
               if (rx_valid_i) begin
                  if (mem_req_o.we) begin
                     state <= soc_pkg::MON_GET_DATA;
                  end else begin
                     mem_req_valid_o <= 1'b1;
                     state           <= soc_pkg::MON_MEM_REQ;
                  end
               end
            end
            soc_pkg::MON_GET_DATA: begin
               if (rx_valid_i) begin
                  mem_req_valid_o <= 1'b1;
                  state           <= soc_pkg::MON_MEM_REQ;
               end
            end
            soc_pkg::MON_MEM_REQ: begin
               // read data is captured in the same cycle the request drops
               if (mem_ack_i) begin
                  mem_req_valid_o <= 1'b0;
                  state           <= soc_pkg::MON_WAIT_ACK_LOW;
               end
            end
            soc_pkg::MON_WAIT_ACK_LOW: begin
               if (!mem_ack_i) begin
                  state <= soc_pkg::MON_SEND;
               end
            end
            soc_pkg::MON_SEND: begin
               if (!tx_busy_i) begin
                  tx_start_o <= 1'b1;
                  state      <= soc_pkg::MON_IDLE;
               end
            end
            soc_pkg::MON_TRAP: begin
               state <= soc_pkg::MON_TRAP;
            end
            default: state <= soc_pkg::MON_IDLE;
         endcase
      end
   end

   // request fields stay put from the operand bytes until the next command
   always_ff @(posedge clk_i) begin
      if (rx_valid_i) begin
         unique case (state)
            soc_pkg::MON_IDLE: begin
               mem_req_o.we <= (rx_byte_i == soc_pkg::CMD_WRITE);
            end
            soc_pkg::MON_GET_ADDR: begin
               mem_req_o.addr <= rx_byte_i;
            end
            soc_pkg::MON_GET_DATA: begin
               mem_req_o.wdata <= rx_byte_i;
            end
            default: begin
            end
         endcase
      end
   end

   // reply byte held until the transmitter takes it
   always_ff @(posedge clk_i) begin
      if ((state == soc_pkg::MON_MEM_REQ) && mem_ack_i) begin
         tx_byte_o <= mem_req_o.we ? soc_pkg::RSP_OK : mem_rdata_i;
      end
   end

endmodule

`default_nettype wire

// File: hdl/reset_ctrl.sv
`default_nettype none

module reset_ctrl #(
   parameter int RST_START    = 5,
   parameter int RST_DURATION = 10
) (
   input  wire  clk_i,
   input  wire  arst_n_i,
   output logic sys_rst_n_o
);

   localparam int TOTAL = RST_START + RST_DURATION;
   localparam int CNT_W = $clog2(TOTAL + 1);

   localparam logic [CNT_W-1:0] START_CNT = CNT_W'(RST_START);
   localparam logic [CNT_W-1:0] END_CNT   = CNT_W'(TOTAL);

   logic [1:0]       start_sync;
   logic             start;
   logic [CNT_W-1:0] cnt;
   logic             pulse;
   logic             pulse_q;

   // deassertion synchronizer, start comes up two clocks after release
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         start_sync <= 2'b00;
      end else begin
         start_sync <= {start_sync[0], 1'b1};
      end
   end

   assign start = start_sync[1];

   // reset pulse window measured from start
   assign pulse = start && (cnt >= START_CNT) && (cnt < END_CNT);

   // the board reset may never be pressed, so the system is held
   // in reset until the generated pulse has gone by
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         cnt         <= '0;
         pulse_q     <= 1'b0;
         sys_rst_n_o <= 1'b0;
      end else begin
         if (start && (cnt != END_CNT)) begin
            cnt <= cnt + 1'b1;
         end
         pulse_q <= pulse;
         // falling edge of the pulse releases the system
         if (pulse_q && !pulse) begin
            sys_rst_n_o <= 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// File: hdl/soc_pkg.sv
`default_nettype none

package soc_pkg;

   // one uart byte or one memory data byte
   typedef logic [7:0] byte_t;

   // external byte memory address
   typedef logic [7:0] mem_addr_t;

   // one request on the external memory port
   typedef struct packed {
      // set for a write, clear for a read
      logic      we;
      mem_addr_t addr;
      // ignored by the memory on reads
      byte_t     wdata;
   } mem_req_t;

   // opcode of a write command, followed by address and data
   localparam byte_t CMD_WRITE = 8'h57;

   // opcode of a read command, followed by address
   localparam byte_t CMD_READ = 8'h52;

   // reply byte sent once a write is done
   localparam byte_t RSP_OK = 8'h4B;

   // command monitor states
   typedef enum logic [2:0] {
      // waiting for an opcode
      MON_IDLE,
      // waiting for the address byte
      MON_GET_ADDR,
      // waiting for the write data byte
      MON_GET_DATA,
      // request raised, waiting for ack high
      MON_MEM_REQ,
      // request dropped, waiting for ack low
      MON_WAIT_ACK_LOW,
      // reply queued until the transmitter is free
      MON_SEND,
      // unknown opcode seen, stuck until reset
      MON_TRAP
   } mon_state_t;

endpackage

`default_nettype wire

// File: hdl/soc_top.sv
`default_nettype none

module soc_top #(
   parameter int CLKS_PER_BIT = 8,
   parameter int RST_START    = 5,
   parameter int RST_DURATION = 10
) (
   input  wire               clk_i,
   input  wire               arst_n_i,
   // uart
   input  wire               uart_rxd_i,
   output logic              uart_txd_o,
   // external byte memory
   output soc_pkg::mem_req_t mem_req_o,
   output logic              mem_req_valid_o,
   input  wire               mem_ack_i,
   input  soc_pkg::byte_t    mem_rdata_i,
   output logic              trap_o
);

   logic           sys_rst_n;
   logic           rx_valid;
   soc_pkg::byte_t rx_byte;
   logic           tx_start;
   soc_pkg::byte_t tx_byte;
   logic           tx_busy;

   // board reset synchronized and stretched for the rest of the system
   reset_ctrl #(
      .RST_START   (RST_START),
      .RST_DURATION(RST_DURATION)
   ) reset_ctrl_i (
      .clk_i      (clk_i),
      .arst_n_i   (arst_n_i),
      .sys_rst_n_o(sys_rst_n)
   );

   uart_rx #(
      .CLKS_PER_BIT(CLKS_PER_BIT)
   ) uart_rx_i (
      .clk_i     (clk_i),
      .arst_n_i  (sys_rst_n),
      .rxd_i     (uart_rxd_i),
      .rx_valid_o(rx_valid),
      .rx_byte_o (rx_byte)
   );

   uart_tx #(
      .CLKS_PER_BIT(CLKS_PER_BIT)
   ) uart_tx_i (
      .clk_i     (clk_i),
      .arst_n_i  (sys_rst_n),
      .tx_start_i(tx_start),
      .tx_byte_i (tx_byte),
      .txd_o     (uart_txd_o),
      .tx_busy_o (tx_busy)
   );

   cmd_monitor cmd_monitor_i (
      .clk_i          (clk_i),
      .arst_n_i       (sys_rst_n),
      .rx_valid_i     (rx_valid),
      .rx_byte_i      (rx_byte),
      .tx_busy_i      (tx_busy),
      .tx_start_o     (tx_start),
      .tx_byte_o      (tx_byte),
      .mem_req_o      (mem_req_o),
      .mem_req_valid_o(mem_req_valid_o),
      .mem_ack_i      (mem_ack_i),
      .mem_rdata_i    (mem_rdata_i),
      .trap_o         (trap_o)
   );

endmodule

`default_nettype wire

// File: hdl/uart_rx.sv
`default_nettype none

module uart_rx #(
   parameter int CLKS_PER_BIT = 8
) (
   input  wire            clk_i,
   input  wire            arst_n_i,
   input  wire            rxd_i,
   output logic           rx_valid_o,
   output soc_pkg::byte_t rx_byte_o
);

   localparam int CNT_W = $clog2(CLKS_PER_BIT);

   localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(CLKS_PER_BIT - 1);
   localparam logic [CNT_W-1:0] MID_CNT  = CNT_W'(CLKS_PER_BIT / 2 - 1);

   typedef enum logic [1:0] {
      RX_IDLE,
      RX_START,
      RX_DATA,
      RX_STOP
   } rx_state_t;

   rx_state_t        state;
   logic [1:0]       rxd_sync;
   logic             rxd_s;
   logic [CNT_W-1:0] clk_cnt;
   logic [2:0]       bit_idx;

   // line idles high
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         rxd_sync <= 2'b11;
      end else begin
         rxd_sync <= {rxd_sync[0], rxd_i};
      end
   end

   assign rxd_s = rxd_sync[1];

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state      <= RX_IDLE;
         clk_cnt    <= '0;
         bit_idx    <= '0;
         rx_valid_o <= 1'b0;
      end else begin
         rx_valid_o <= 1'b0;
         unique case (state)
            RX_IDLE: begin
               clk_cnt <= '0;
               bit_idx <= '0;
               if (!rxd_s) begin
                  state <= RX_START;
               end
            end
            RX_START: begin
               // recheck the start bit at its middle, glitches go back to idle
               if (clk_cnt == MID_CNT) begin
                  clk_cnt <= '0;
                  state   <= rxd_s ? RX_IDLE : RX_DATA;
               end else begin
                  clk_cnt <= clk_cnt + 1'b1;
               end
            end
            RX_DATA: begin
               if (clk_cnt == LAST_CNT) begin
                  clk_cnt <= '0;
                  bit_idx <= bit_idx + 1'b1;
                  if (bit_idx == 3'd7) begin
                     state <= RX_STOP;
                  end
               end else begin
                  clk_cnt <= clk_cnt + 1'b1;
               end
            end
            RX_STOP: begin
               if (clk_cnt == LAST_CNT) begin
                  // framing error drops the byte
                  rx_valid_o <= rxd_s;
                  state      <= RX_IDLE;
               end else begin
                  clk_cnt <= clk_cnt + 1'b1;
               end
            end
            default: state <= RX_IDLE;
         endcase
      end
   end

   // lsb first, sampled mid-bit
   always_ff @(posedge clk_i) begin
      if ((state == RX_DATA) && (clk_cnt == LAST_CNT)) begin
         rx_byte_o <= {rxd_s, rx_byte_o[7:1]};
      end
   end

endmodule

`default_nettype wire

// File: hdl/uart_tx.sv
`default_nettype none

module uart_tx #(
   parameter int CLKS_PER_BIT = 8
) (
   input  wire            clk_i,
   input  wire            arst_n_i,
   input  wire            tx_start_i,
   input  soc_pkg::byte_t tx_byte_i,
   output logic           txd_o,
   output logic           tx_busy_o
);

   localparam int CNT_W = $clog2(CLKS_PER_BIT);

   localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(CLKS_PER_BIT - 1);
   localparam logic [3:0]       LAST_BIT = 4'd9;

   logic [CNT_W-1:0] clk_cnt;
   logic [3:0]       bit_cnt;
   logic [9:0]       frame;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         tx_busy_o <= 1'b0;
         clk_cnt   <= '0;
         bit_cnt   <= '0;
      end else if (!tx_busy_o) begin
         clk_cnt <= '0;
         bit_cnt <= '0;
         if (tx_start_i) begin
            tx_busy_o <= 1'b1;
         end
      end else if (clk_cnt == LAST_CNT) begin
         clk_cnt <= '0;
         // stop bit finished
         if (bit_cnt == LAST_BIT) begin
            tx_busy_o <= 1'b0;
         end else begin
            bit_cnt <= bit_cnt + 1'b1;
         end
      end else begin
         clk_cnt <= clk_cnt + 1'b1;
      end
   end

   // stop, data lsb first, start
   always_ff @(posedge clk_i) begin
      if (!tx_busy_o && tx_start_i) begin
         frame <= {1'b1, tx_byte_i, 1'b0};
      end else if (tx_busy_o && (clk_cnt == LAST_CNT)) begin
         frame <= {1'b1, frame[9:1]};
      end
   end

   assign txd_o = tx_busy_o ? frame[0] : 1'b1;

endmodule

`default_nettype wire

// File: sim.f
hdl/soc_pkg.sv
hdl/reset_ctrl.sv
hdl/uart_rx.sv
hdl/uart_tx.sv
hdl/cmd_monitor.sv
hdl/soc_top.sv
testbench/tb_mem_model.sv
testbench/tb_soc_top.sv

// File: testbench/tb_mem_model.sv
`default_nettype none

module tb_mem_model (
   input  wire               clk_i,
   input  wire               arst_n_i,
   input  soc_pkg::mem_req_t req_i,
   input  wire               req_valid_i,
   output logic              ack_o   = 1'b0,
   output soc_pkg::byte_t    rdata_o = '0
);

   typedef enum logic [1:0] {
      PH_IDLE,
      PH_DELAY,
      PH_ACKED
   } phase_t;

   // contents and last write are read by the testbench
   soc_pkg::byte_t     mem [256];
   soc_pkg::mem_addr_t wr_addr;
   soc_pkg::byte_t     wr_data;
   // set when a request changes or drops before its ack
   logic               proto_err;

   soc_pkg::mem_req_t  held;
   phase_t             phase;
   logic [2:0]         delay;
   logic               filled = 1'b0;

   always @(negedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         ack_o     <= 1'b0;
         rdata_o   <= '0;
         phase     <= PH_IDLE;
         delay     <= '0;
         proto_err <= 1'b0;
         wr_addr   <= '0;
         wr_data   <= '0;
         // random preload, once per run
         if (!filled) begin
            for (int i = 0; i < 256; i++) begin
               mem[i] <= soc_pkg::byte_t'($urandom);
            end
            filled <= 1'b1;
         end
      end else begin
         case (phase)
            PH_IDLE: begin
               if (req_valid_i) begin
                  held  <= req_i;
                  delay <= 3'($urandom_range(7, 0));
                  phase <= PH_DELAY;
               end
            end
            PH_DELAY: begin
               if (!req_valid_i || (req_i != held)) begin
                  proto_err <= 1'b1;
               end
               if (delay == 3'd0) begin
                  ack_o <= 1'b1;
                  phase <= PH_ACKED;
                  if (held.we) begin
                     mem[held.addr] <= held.wdata;
                     wr_addr        <= held.addr;
                     wr_data        <= held.wdata;
                  end else begin
                     rdata_o <= mem[held.addr];
                  end
               end else begin
                  delay <= delay - 1'b1;
               end
            end
            PH_ACKED: begin
               // ack drops only once the request is gone
               if (!req_valid_i) begin
                  ack_o <= 1'b0;
                  phase <= PH_IDLE;
               end else if (req_i != held) begin
                  proto_err <= 1'b1;
               end
            end
            default: phase <= PH_IDLE;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: testbench/tb_soc_top.sv
`default_nettype none

module tb_soc_top;

   localparam int CLKS_PER_BIT  = 8;
   localparam int FRAME_CLKS    = 10 * CLKS_PER_BIT;
   // bound on command turnaround with the slowest memory
   localparam int REPLY_TIMEOUT = 4 * FRAME_CLKS;

   logic              clk;
   logic              arst_n;
   logic              uart_rxd;
   logic              uart_txd;
   soc_pkg::mem_req_t mem_req;
   logic              mem_req_valid;
   logic              mem_ack;
   soc_pkg::byte_t    mem_rdata;
   logic              trap;

   // reference copy of the external memory
   soc_pkg::byte_t     ref_mem [256];
   soc_pkg::mem_addr_t last_wr_addr;
   int unsigned        seed_val;

   soc_top #(
      .CLKS_PER_BIT(CLKS_PER_BIT)
   ) soc_top_i (
      .clk_i          (clk),
      .arst_n_i       (arst_n),
      .uart_rxd_i     (uart_rxd),
      .uart_txd_o     (uart_txd),
      .mem_req_o      (mem_req),
      .mem_req_valid_o(mem_req_valid),
      .mem_ack_i      (mem_ack),
      .mem_rdata_i    (mem_rdata),
      .trap_o         (trap)
   );

   tb_mem_model mem_model_i (
      .clk_i      (clk),
      .arst_n_i   (arst_n),
      .req_i      (mem_req),
      .req_valid_i(mem_req_valid),
      .ack_o      (mem_ack),
      .rdata_o    (mem_rdata)
   );

   always #2 clk = ~clk;

   task automatic abort_run(input string reason);
      $display("%s", reason);
      $display("Simulation failed");
      $fatal(1, "run stopped at first error");
   endtask

   task automatic check_byte(input string name, input soc_pkg::byte_t got,
                             input soc_pkg::byte_t exp);
      if (got !== exp) begin
         abort_run($sformatf("ERR %s got 0x%02h expected 0x%02h", name, got, exp));
      end
   endtask

   task automatic check_addr(input string name, input soc_pkg::mem_addr_t got,
                             input soc_pkg::mem_addr_t exp);
      if (got !== exp) begin
         abort_run($sformatf("ERR %s got 0x%02h expected 0x%02h", name, got, exp));
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         abort_run($sformatf("ERR %s got 0x%h expected 0x%h", name, got, exp));
      end
   endtask

   // 8N1 frame, stop_bit low gives a framing error
   task automatic send_frame(input soc_pkg::byte_t data, input logic stop_bit);
      logic [9:0] frame;
      frame = {stop_bit, data, 1'b0};
      for (int i = 0; i < 10; i++) begin
         uart_rxd = frame[i];
         repeat (CLKS_PER_BIT) @(negedge clk);
      end
      uart_rxd = 1'b1;
   endtask

   task automatic recv_frame(output soc_pkg::byte_t data);
      int waited;
      waited = 0;
      while (uart_txd !== 1'b0) begin
         if (waited == REPLY_TIMEOUT) begin
            abort_run("no reply frame arrived on uart_txd_o in time");
         end
         @(negedge clk);
         waited++;
      end
      // move to the middle of the start bit
      repeat (CLKS_PER_BIT / 2) @(negedge clk);
      check_bit("uart_txd_o start bit", uart_txd, 1'b0);
      for (int i = 0; i < 8; i++) begin
         repeat (CLKS_PER_BIT) @(negedge clk);
         data[i] = uart_txd;
      end
      repeat (CLKS_PER_BIT) @(negedge clk);
      check_bit("uart_txd_o stop bit", uart_txd, 1'b1);
   endtask

   task automatic expect_silence(input int cycles);
      repeat (cycles) begin
         @(negedge clk);
         check_bit("uart_txd_o", uart_txd, 1'b1);
         check_bit("mem_req_valid_o", mem_req_valid, 1'b0);
      end
   endtask

   task automatic run_command(input logic is_write, input soc_pkg::mem_addr_t addr,
                              input soc_pkg::byte_t data);
      soc_pkg::byte_t reply;
      send_frame(is_write ? soc_pkg::CMD_WRITE : soc_pkg::CMD_READ, 1'b1);
      send_frame(addr, 1'b1);
      if (is_write) begin
         send_frame(data, 1'b1);
      end
      recv_frame(reply);
      if (is_write) begin
         check_byte("uart_txd_o write reply", reply, soc_pkg::RSP_OK);
         check_addr("mem_req_o.addr", mem_model_i.wr_addr, addr);
         check_byte("mem_req_o.wdata", mem_model_i.wr_data, data);
         ref_mem[addr] = data;
         last_wr_addr  = addr;
      end else begin
         check_byte("uart_txd_o read reply", reply, ref_mem[addr]);
      end
      check_bit("mem_req_o held until ack", mem_model_i.proto_err, 1'b0);
      check_bit("trap_o", trap, 1'b0);
   endtask

   initial begin
      int                 writes_left;
      int                 reads_left;
      int                 waited;
      logic               do_wr;
      soc_pkg::mem_addr_t addr;
      soc_pkg::byte_t     op;
      seed_val = $urandom(10);
      clk      = 1'b0;
      arst_n   = 1'b0;
      uart_rxd = 1'b1;
      repeat (2) @(negedge clk);
      arst_n = 1'b1;

      // outputs stay idle while the stretched reset runs
      waited = 0;
      while (soc_top_i.sys_rst_n !== 1'b1) begin
         if (waited == FRAME_CLKS) begin
            abort_run("system reset was never released");
         end
         @(negedge clk);
         check_bit("uart_txd_o", uart_txd, 1'b1);
         check_bit("mem_req_valid_o", mem_req_valid, 1'b0);
         check_bit("trap_o", trap, 1'b0);
         waited++;
      end
      for (int i = 0; i < 256; i++) begin
         ref_mem[i] = mem_model_i.mem[i];
      end

      writes_left  = 40;
      reads_left   = 40;
      last_wr_addr = soc_pkg::mem_addr_t'($urandom);
      for (int n = 0; (writes_left + reads_left) > 0; n++) begin
         if ((n % 20) == 7) begin
            // frame with a bad stop bit must vanish
            send_frame(soc_pkg::byte_t'($urandom), 1'b0);
            expect_silence(2 * FRAME_CLKS);
         end
         do_wr = (reads_left == 0) || ((writes_left > 0) && (($urandom % 2) == 0));
         addr  = soc_pkg::mem_addr_t'($urandom);
         if (!do_wr && (($urandom % 2) == 0)) begin
            addr = last_wr_addr;
         end
         run_command(do_wr, addr, soc_pkg::byte_t'($urandom));
         if (do_wr) begin
            writes_left--;
         end else begin
            reads_left--;
         end
      end

      // unknown opcode traps, later commands are ignored
      op = soc_pkg::byte_t'($urandom);
      if ((op == soc_pkg::CMD_WRITE) || (op == soc_pkg::CMD_READ)) begin
         op = op ^ 8'h80;
      end
      send_frame(op, 1'b1);
      waited = 0;
      while (trap !== 1'b1) begin
         if (waited == FRAME_CLKS) begin
            abort_run("trap_o did not rise after an unknown opcode");
         end
         @(negedge clk);
         waited++;
      end
      send_frame(soc_pkg::CMD_READ, 1'b1);
      send_frame(soc_pkg::byte_t'($urandom), 1'b1);
      expect_silence(REPLY_TIMEOUT);
      check_bit("trap_o", trap, 1'b1);

      $display("Simulation passed");
      $finish;
   end

endmodule

`default_nettype wire
